//--- verilog.f
+incdir+include
hdl/spdif_pkg.sv
hdl/spdif_dai.sv
hdl/biphase_decoder.sv
hdl/subframe_assembler.sv
hdl/channel_status_tracker.sv
hdl/spdif_rx_top.sv
tests/spdif_rx_assert.sv
tests/spdif_rx_tb.sv

//--- Makefile
TOP = spdif_rx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

//--- tests/spdif_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spdif_params.svh"

module spdif_rx_tb;
    import spdif_pkg::*;

    localparam int HALF = `SPDIF_CLK_PER_HALF;
    localparam int SUBFRAMES = 410;
    localparam int EXTRA_HALVES = 352;  // idle, noise, loss and tail
    localparam int CYCLE_LIMIT = (SUBFRAMES * 64 + EXTRA_HALVES) * HALF * 3 / 2;

    logic                      clk;
    logic                      rst;
    logic                      signal;
    logic                      locked;
    logic                      sf_valid;
    subframe_t                 sf;
    logic                      cs_valid;
    logic [`SPDIF_CS_BITS-1:0] cs_word;
    logic                      coding_error;

    logic [31:0]               rng = 32'h2906_dcf8;
    logic                      lvl;  // line level after the last half-cell
    logic [`SPDIF_CS_BITS-1:0] cs_exp;
    subframe_t                 exp_q[$];
    string                     name_q[$];
    int                        seq_errors = 0;
    int                        mon_errors = 0;
    int                        sf_count = 0;
    int                        cs_count = 0;
    int                        cerr_count = 0;
    int                        cycles;
    logic                      lock_seen = 1'b0;

    spdif_rx_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .signal       (signal),
        .locked       (locked),
        .sf_valid     (sf_valid),
        .sf           (sf),
        .cs_valid     (cs_valid),
        .cs_word      (cs_word),
        .coding_error (coding_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic subframe_t expected_subframe(input preamble_e kind, input logic [19:0] audio,
                                                    input logic [3:0] aux, input logic v,
                                                    input logic u, input logic c, input logic p);
        subframe_t e;
        e.channel_b          = kind == pre_w;
        e.block_start        = kind == pre_b;
        e.sample.split.audio = audio;
        e.sample.split.aux   = aux;
        e.validity           = v;
        e.user               = u;
        e.cs                 = c;
        e.parity_ok          = ~(^{audio, aux, v, u, c, p});  // slots 4..31 carry even parity
        return e;
    endfunction

    function automatic int check_value(input string test, input string field,
                                       input logic [31:0] exp, input logic [31:0] act);
        int bad;
        bad = 0;
        assert (act === exp) else begin
            $display("** Error [%s] %s: expected %0h, actual %0h", test, field, exp, act);
            bad = 1;
        end
        return bad;
    endfunction

    task automatic drive_half(input logic level);
        repeat (HALF) begin
            @(negedge clk);
            signal = level;
        end
    endtask

    task automatic hold_level(input int halves);
        repeat (halves) drive_half(lvl);
    endtask

    task automatic drive_noise(input int clocks);
        repeat (clocks) begin
            rng = xorshift(rng);
            @(negedge clk);
            signal = rng[9];
        end
        lvl = signal;
    endtask

    // skip_cell leaves out the opening transition of one payload cell
    task automatic send_subframe(input preamble_e kind, input logic expect_rx, input logic flip_p,
                                 input int skip_cell, input string name, output logic c);
        logic [19:0] audio;
        logic [3:0]  aux;
        logic        v;
        logic        u;
        logic        p;
        logic [27:0] payload;
        logic [7:0]  pat;
        int          i;
        rng = xorshift(rng);
        {c, u, v, aux, audio} = rng[26:0];
        p = ^{audio, aux, v, u, c} ^ flip_p;
        if (expect_rx) begin
            exp_q.push_back(expected_subframe(kind, audio, aux, v, u, c, p));
            name_q.push_back(name);
        end
        case (kind)
            pre_b:   pat = 8'b1110_1000;
            pre_m:   pat = 8'b1110_0010;
            default: pat = 8'b1110_0100;
        endcase
        if (lvl) pat = ~pat;  // the preamble always opens against the line level
        for (i = 7; i >= 0; i--) drive_half(pat[i]);
        lvl = pat[0];
        payload = {p, c, u, v, audio, aux};  // slot 4 goes out first
        for (i = 0; i < 28; i++) begin
            if (i != skip_cell) lvl = ~lvl;
            drive_half(lvl);
            if (payload[i]) lvl = ~lvl;
            drive_half(lvl);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && locked) lock_seen = 1'b1;
        if (!rst && coding_error) cerr_count++;
    end

    always @(negedge clk) begin : compare_outputs
        subframe_t e;
        string     t;
        if (!rst && sf_valid) begin
            sf_count++;
            assert (exp_q.size() != 0) else begin
                $display("subframe received although none was expected");
                mon_errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                t = name_q.pop_front();
                mon_errors += check_value(t, "raw", 32'(e.sample.raw), 32'(sf.sample.raw));
                mon_errors += check_value(t, "audio", 32'(e.sample.split.audio),
                                          32'(sf.sample.split.audio));
                mon_errors += check_value(t, "aux", 32'(e.sample.split.aux),
                                          32'(sf.sample.split.aux));
                mon_errors += check_value(t, "channel_b", 32'(e.channel_b), 32'(sf.channel_b));
                mon_errors += check_value(t, "block_start", 32'(e.block_start),
                                          32'(sf.block_start));
                mon_errors += check_value(t, "validity", 32'(e.validity), 32'(sf.validity));
                mon_errors += check_value(t, "user", 32'(e.user), 32'(sf.user));
                mon_errors += check_value(t, "cs", 32'(e.cs), 32'(sf.cs));
                mon_errors += check_value(t, "parity_ok", 32'(e.parity_ok), 32'(sf.parity_ok));
            end
        end
        if (!rst && cs_valid) begin
            cs_count++;
            mon_errors += check_value("status", "cs_word", 32'(cs_exp), 32'(cs_word));
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the stream never finished", cycles);
        $display("errors: %0d stimulus, %0d outputs", seq_errors, mon_errors);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        logic c;
        int   f;
        int   snap;
        rst = 1'b1;
        signal = 1'b0;
        lvl = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        hold_level(80);
        drive_noise(64 * HALF);
        hold_level(80);  // long enough for any half-read pattern to be dropped
        seq_errors += check_value("lock", "lock during idle or noise", 32'd0, 32'(lock_seen));

        // a single preamble only arms the lock, so its subframe is never delivered
        send_subframe(pre_m, 1'b0, 1'b0, -1, "lock", c);
        seq_errors += check_value("lock", "lock after one preamble", 32'd0, 32'(lock_seen));
        send_subframe(pre_w, 1'b1, 1'b0, -1, "lock", c);
        seq_errors += check_value("lock", "lock after two preambles", 32'd1, 32'(locked));
        for (f = 189; f < `SPDIF_BLOCK_FRAMES; f++) begin
            send_subframe(pre_m, 1'b1, 1'b0, -1, "audio", c);
            send_subframe(pre_w, 1'b1, 1'b0, -1, "audio", c);
        end

        for (f = 0; f < `SPDIF_BLOCK_FRAMES; f++) begin
            send_subframe((f == 0) ? pre_b : pre_m, 1'b1, 1'b0, -1, "block", c);
            if (f < `SPDIF_CS_BITS) cs_exp[f] = c;
            send_subframe(pre_w, 1'b1, 1'b0, -1, "block", c);
        end

        send_subframe(pre_b, 1'b1, 1'b0, -1, "parity", c);
        send_subframe(pre_w, 1'b1, 1'b1, -1, "parity", c);
        send_subframe(pre_m, 1'b1, 1'b0, -1, "parity", c);
        send_subframe(pre_w, 1'b1, 1'b0, -1, "parity", c);
        send_subframe(pre_m, 1'b0, 1'b0, 10, "coding", c);  // cell loses its bit, subframe dropped
        send_subframe(pre_w, 1'b1, 1'b0, -1, "coding", c);

        hold_level(8);
        snap = sf_count;
        hold_level(88);
        seq_errors += check_value("loss", "locked after quiet line", 32'd0, 32'(locked));
        seq_errors += check_value("loss", "subframes during loss", 32'(snap), 32'(sf_count));

        send_subframe(pre_m, 1'b0, 1'b0, -1, "relock", c);
        for (f = 0; f < 11; f++) begin
            send_subframe((f % 2 == 0) ? pre_w : pre_m, 1'b1, 1'b0, -1, "relock", c);
        end
        seq_errors += check_value("relock", "locked after resume", 32'd1, 32'(locked));
        hold_level(32);

        seq_errors += check_value("end", "pending subframes", 32'd0, 32'(exp_q.size()));
        seq_errors += check_value("status", "cs_valid count", 32'd1, 32'(cs_count));
        seq_errors += check_value("coding", "coding_error count", 32'd1, 32'(cerr_count));

        $display("errors: %0d stimulus, %0d outputs, %0d subframes received",
                 seq_errors, mon_errors, sf_count);
        if (seq_errors + mon_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/spdif_rx_assert.sv
`timescale 1ns/1ps
`default_nettype none

module spdif_rx_assert (
    input logic clk,
    input logic rst,
    input logic locked,
    input logic sf_valid,
    input logic cs_valid,
    input logic pre_valid,
    input logic hc_valid
);

    // outputs only leave the receiver while it tracks the stream
    a_out_locked: assert property (@(posedge clk) disable iff (rst)
        (sf_valid || cs_valid) |-> locked)
        else $error("subframe or channel status strobe while unlocked");

    a_pre_single: assert property (@(posedge clk) disable iff (rst)
        pre_valid |=> !pre_valid)
        else $error("preamble strobe longer than one cycle");

    a_hc_outside_pre: assert property (@(posedge clk) disable iff (rst)
        !(hc_valid && pre_valid))
        else $error("half-cell strobe together with preamble strobe");

endmodule

bind spdif_rx_top spdif_rx_assert i_assert (
    .clk       (clk),
    .rst       (rst),
    .locked    (locked),
    .sf_valid  (sf_valid),
    .cs_valid  (cs_valid),
    .pre_valid (pre_valid),
    .hc_valid  (hc_valid)
);

`default_nettype wire

//--- hdl/spdif_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spdif_params.svh"

module spdif_rx_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      signal,
    output logic                      locked,
    output logic                      sf_valid,
    output spdif_pkg::subframe_t      sf,
    output logic                      cs_valid,
    output logic [`SPDIF_CS_BITS-1:0] cs_word,
    output logic                      coding_error
);
    import spdif_pkg::*;

    logic       hc_valid;
    half_cell_t hc;
    logic       pre_valid;
    preamble_e  pre_kind;
    logic       bit_valid;
    logic       bit_value;

    spdif_dai i_dai (
        .clk       (clk),
        .rst       (rst),
        .signal    (signal),
        .locked    (locked),
        .pre_valid (pre_valid),
        .pre_kind  (pre_kind),
        .hc_valid  (hc_valid),
        .hc        (hc)
    );

    biphase_decoder i_bmc (
        .clk          (clk),
        .rst          (rst),
        .hc_valid     (hc_valid),
        .hc           (hc),
        .bit_valid    (bit_valid),
        .bit_value    (bit_value),
        .coding_error (coding_error)
    );

    subframe_assembler i_asm (
        .clk       (clk),
        .rst       (rst),
        .pre_valid (pre_valid),
        .pre_kind  (pre_kind),
        .bit_valid (bit_valid),
        .bit_value (bit_value),
        .sf_valid  (sf_valid),
        .sf        (sf)
    );

    channel_status_tracker i_cst (
        .clk      (clk),
        .rst      (rst),
        .sf_valid (sf_valid),
        .sf       (sf),
        .cs_valid (cs_valid),
        .cs_word  (cs_word)
    );

endmodule

`default_nettype wire

//--- hdl/channel_status_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "spdif_params.svh"

module channel_status_tracker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     sf_valid,
    input  spdif_pkg::subframe_t     sf,
    output logic                     cs_valid,
    output logic [`SPDIF_CS_BITS-1:0] cs_word
);

    localparam int FRAMES = `SPDIF_BLOCK_FRAMES;
    localparam int IDX_W = $clog2(FRAMES);
    localparam int CSB = `SPDIF_CS_BITS;
    localparam logic [IDX_W-1:0] LAST_FRAME = IDX_W'(FRAMES - 1);

    logic             in_block;
    logic [IDX_W-1:0] frame_idx;  // index the next left subframe will take
    logic [IDX_W-1:0] cur_idx;
    logic [CSB-1:0]   cs_shift;
    logic             count;

    assign cur_idx = sf.block_start ? '0 : frame_idx;

    // right subframes carry their own copy of the C bits and are skipped
    assign count = sf_valid && !sf.channel_b && (in_block || sf.block_start);

    always_ff @(posedge clk) begin
        if (rst) begin
            in_block  <= 1'b0;
            frame_idx <= '0;
            cs_valid  <= 1'b0;
        end else begin
            cs_valid <= count && (cur_idx == LAST_FRAME);
            if (count) begin
                frame_idx <= cur_idx + 1'b1;
                in_block  <= cur_idx != LAST_FRAME;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (count && cur_idx < IDX_W'(CSB)) begin
            cs_shift <= {sf.cs, cs_shift[CSB-1:1]};  // bit 0 of the word comes from frame 0
        end
        if (count && cur_idx == LAST_FRAME) begin
            cs_word <= cs_shift;
        end
    end

endmodule

`default_nettype wire

//--- hdl/subframe_assembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "spdif_params.svh"

module subframe_assembler (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pre_valid,
    input  spdif_pkg::preamble_e pre_kind,
    input  logic                 bit_valid,
    input  logic                 bit_value,
    output logic                 sf_valid,
    output spdif_pkg::subframe_t sf
);
    import spdif_pkg::*;

    localparam int NBITS = `SPDIF_PAYLOAD_BITS;
    localparam int CNT_W = $clog2(NBITS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(NBITS - 1);

    preamble_e        kind;
    logic             active;
    logic [CNT_W-1:0] bit_cnt;
    logic             parity;
    logic [NBITS-1:0] shift;
    logic [NBITS-1:0] shift_next;
    logic             take;
    logic             emit;

    // slot 4 arrives first and settles in bit 0
    assign shift_next = {bit_value, shift[NBITS-1:1]};

    assign take = bit_valid && active && !pre_valid;
    assign emit = take && (bit_cnt == LAST_BIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            kind     <= pre_none;
            active   <= 1'b0;
            bit_cnt  <= '0;
            parity   <= 1'b0;
            sf_valid <= 1'b0;
        end else begin
            sf_valid <= emit;
            if (pre_valid) begin
                kind    <= pre_kind;   // any partial subframe is dropped here
                active  <= pre_kind != pre_none;
                bit_cnt <= '0;
                parity  <= 1'b0;
            end else if (take) begin
                parity <= parity ^ bit_value;
                if (emit) begin
                    active  <= 1'b0;
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            shift <= shift_next;
        end
        if (emit) begin
            sf.channel_b   <= kind == pre_w;
            sf.block_start <= kind == pre_b;
            sf.sample.raw  <= shift_next[23:0];
            sf.validity    <= shift_next[24];
            sf.user        <= shift_next[25];
            sf.cs          <= shift_next[26];
            sf.parity_ok   <= ~(parity ^ bit_value);  // even parity over slots 4..31
        end
    end

endmodule

`default_nettype wire

//--- hdl/biphase_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module biphase_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hc_valid,
    input  spdif_pkg::half_cell_t hc,
    output logic                  bit_valid,
    output logic                  bit_value,
    output logic                  coding_error
);

    logic have_first;    // first half of the current cell is held
    logic first_lvl;
    logic last_lvl;      // second half of the previous cell
    logic boundary_err;

    always_ff @(posedge clk) begin
        if (rst) begin
            have_first   <= 1'b0;
            boundary_err <= 1'b0;
            bit_valid    <= 1'b0;
            coding_error <= 1'b0;
        end else begin
            bit_valid    <= 1'b0;
            coding_error <= 1'b0;
            if (hc_valid) begin
                if (hc.first || !have_first) begin
                    have_first   <= 1'b1;
                    first_lvl    <= hc.level;
                    // every cell has to open with a transition
                    boundary_err <= !hc.first && (hc.level == last_lvl);
                end else begin
                    have_first <= 1'b0;
                    last_lvl   <= hc.level;
                    if (boundary_err) begin
                        coding_error <= 1'b1;
                    end else begin
                        bit_valid <= 1'b1;
                        bit_value <= first_lvl ^ hc.level;  // a mid-cell transition is a 1
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/spdif_dai.sv
`timescale 1ns/1ps
`default_nettype none

`include "spdif_params.svh"

module spdif_dai (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  signal,
    output logic                  locked,
    output logic                  pre_valid,
    output spdif_pkg::preamble_e  pre_kind,
    output logic                  hc_valid,
    output spdif_pkg::half_cell_t hc
);
    import spdif_pkg::*;

    localparam int HALF = `SPDIF_CLK_PER_HALF;
    localparam int PHASE_W = (HALF > 1) ? $clog2(HALF) : 1;
    localparam int RUN_MAX = 3 * HALF;
    localparam int RUN_W = $clog2(RUN_MAX + 1);
    localparam logic [PHASE_W-1:0] MID = PHASE_W'(HALF / 2);
    localparam logic [PHASE_W-1:0] PHASE_END = PHASE_W'(HALF - 1);
    localparam logic [5:0] FIRST_DATA = 6'(`SPDIF_PREAMBLE_HALVES);
    localparam logic [5:0] LAST_PRE = 6'(`SPDIF_PREAMBLE_HALVES - 1);

    typedef enum logic [1:0] {
        st_find,
        st_read,
        st_lock
    } state_e;

    function automatic preamble_e classify(input logic [7:0] pat);
        logic [7:0] p;
        p = pat[7] ? pat : ~pat;  // fold the inverted patterns onto a leading 1
        case (p)
            8'b1110_1000: classify = pre_b;
            8'b1110_0010: classify = pre_m;
            8'b1110_0100: classify = pre_w;
            default:      classify = pre_none;
        endcase
    endfunction

    state_e             state;
    logic               sig_d;
    logic [RUN_W-1:0]   run_cnt;
    logic [RUN_W-1:0]   run_pos;
    logic [PHASE_W-1:0] phase;
    logic [5:0]         half_idx;   // wraps after the 64 half-cells of a subframe
    logic [6:0]         pre_sr;
    logic [7:0]         pattern;
    preamble_e          kind;
    logic               mid;
    logic               violation;

    // clock position inside the current run of equal levels, saturating
    assign run_pos = (signal != sig_d) ? '0 :
                     (run_cnt == RUN_W'(RUN_MAX)) ? run_cnt : run_cnt + 1'b1;

    // last clock of a third half-cell without a transition
    assign violation = run_pos == RUN_W'(RUN_MAX - 1);

    assign mid = phase == MID;
    assign pattern = {pre_sr, signal};
    assign kind = classify(pattern);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_find;
            sig_d     <= 1'b0;
            run_cnt   <= '0;
            phase     <= '0;
            half_idx  <= '0;
            locked    <= 1'b0;
            pre_valid <= 1'b0;
            hc_valid  <= 1'b0;
        end else begin
            sig_d     <= signal;
            run_cnt   <= run_pos;
            pre_valid <= 1'b0;
            hc_valid  <= 1'b0;

            if (phase == PHASE_END) begin
                phase    <= '0;
                half_idx <= half_idx + 1'b1;
            end else begin
                phase <= phase + 1'b1;
            end

            case (state)
                st_find: begin
                    if (violation) begin
                        phase    <= '0;  // the fourth preamble half-cell starts next clock
                        half_idx <= 6'd3;
                        pre_sr   <= {4'b0000, {3{signal}}};
                        state    <= st_read;
                    end
                end
                st_read, st_lock: begin
                    if (mid && half_idx < LAST_PRE) begin
                        pre_sr <= pattern[6:0];
                    end
                    if (mid && half_idx == LAST_PRE) begin
                        if (kind != pre_none) begin
                            pre_valid <= 1'b1;
                            pre_kind  <= kind;
                            locked    <= state == st_lock;  // second preamble in a row
                            state     <= st_lock;
                        end else begin
                            locked <= 1'b0;
                            state  <= st_find;
                        end
                    end
                    if (mid && locked && half_idx >= FIRST_DATA) begin
                        hc_valid <= 1'b1;
                        hc.level <= signal;
                        hc.first <= half_idx == FIRST_DATA;
                    end
                end
                default: state <= st_find;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/spdif_pkg.sv
`default_nettype none

package spdif_pkg;

    // B opens a block on the left channel, M is left and W is right
    typedef enum logic [1:0] {
        pre_none,
        pre_b,
        pre_m,
        pre_w
    } preamble_e;

    typedef struct packed {
        logic level;
        logic first;  // first data half-cell after a preamble
    } half_cell_t;

    typedef struct packed {
        logic [19:0] audio;
        logic [3:0]  aux;
    } sample_split_t;

    // slots 4..27 read as one 24-bit word or as a 20-bit word over aux data
    typedef union packed {
        logic [23:0]   raw;
        sample_split_t split;
    } sample_u;

    typedef struct packed {
        logic    channel_b;    // set for the right channel
        logic    block_start;
        sample_u sample;
        logic    validity;
        logic    user;
        logic    cs;
        logic    parity_ok;
    } subframe_t;

endpackage

`default_nettype wire

//--- include/spdif_params.svh
`ifndef SPDIF_PARAMS_SVH
`define SPDIF_PARAMS_SVH

// clocks per biphase bit cell, kept a multiple of 4 so the half-cell has a clean midpoint
`define SPDIF_CLK_PER_BIT 8

`define SPDIF_CLK_PER_HALF (`SPDIF_CLK_PER_BIT / 2)

`define SPDIF_PREAMBLE_HALVES 8

// aux, audio, V, U, C and P slots that follow the preamble
`define SPDIF_PAYLOAD_BITS 28

`define SPDIF_BLOCK_FRAMES 192

`define SPDIF_CS_BITS 32

`endif
